// ==== verilog/fifoMerge_consts.svh ====
// Merging queue constants shared by the packages and the RTL.

`ifndef FIFOMERGE_CONSTS_SVH
`define FIFOMERGE_CONSTS_SVH

// ------------------------------
// Storage sizing
// ------------------------------

// Entries per channel, counting the pop stage.
`define FIFO_DEPTH 8

// Bits per word.
`define DATA_WIDTH 16

// ------------------------------
// Merging
// ------------------------------

// Producer channels feeding the arbiter.
`define NUM_CHANNELS 2

`endif

// ==== verilog/fifoTypesPkg.sv ====
// Storage types for the per-channel FIFOs covering words, counts and RAM addresses.

`include "fifoMerge_consts.svh"

package fifoTypesPkg;

  // ------------------------------
  // Payload
  // ------------------------------

  // One word as pushed and popped.
  typedef logic [`DATA_WIDTH-1:0] fifoData;

  // ------------------------------
  // Occupancy and addressing
  // ------------------------------

  // Item count from 0 up to a full FIFO.
  typedef logic [$clog2(`FIFO_DEPTH + 1)-1:0] fifoCount;

  // RAM address.
  // The pop stage holds one entry, so the RAM has one entry fewer.
  typedef logic [$clog2(`FIFO_DEPTH - 1)-1:0] ramAddr;

endpackage : fifoTypesPkg

// ==== verilog/arbTypesPkg.sv ====
// Merging types for the channel index, the per-channel pop bus and the tagged output beat.

`include "fifoMerge_consts.svh"

package arbTypesPkg;

  import fifoTypesPkg::*;

  // Index of a producer channel.
  typedef logic [$clog2(`NUM_CHANNELS)-1:0] chanId;

  // Pop side of one channel as seen by the arbiter.
  typedef struct packed {
    logic valid;
    fifoData data;
  } chanBus;

  // One beat on the shared output, tagged with its source.
  typedef struct packed {
    chanId chan;
    fifoData data;
  } outBeat;

endpackage : arbTypesPkg

// ==== verilog/ramFlops.sv ====
// One-write one-read flop RAM with a registered single-cycle read.

`timescale 1ns/1ps

module ramFlops #(
  parameter int Depth = 7,
  parameter int Width = 16,
  localparam int AddrWidth = (Depth > 1) ? $clog2(Depth) : 1
) (
  input  logic                 clk,

  // Write port.
  input  logic                 wrValid,
  input  logic [AddrWidth-1:0] wrAddr,
  input  logic [Width-1:0]     wrData,

  // Read port.
  input  logic                 rdAddrValid,
  input  logic [AddrWidth-1:0] rdAddr,
  output logic [Width-1:0]     rdData
);

  // ------------------------------
  // Storage
  // ------------------------------

  // Word storage indexed by RAM address.
  logic [Width-1:0] mem [Depth];

  always_ff @(posedge clk) begin
    if (wrValid) begin
      mem[wrAddr] <= wrData;
    end
  end

  // ------------------------------
  // Read register
  // ------------------------------

  // Loads only on a read strobe.
  // It holds the last word otherwise, so the controller can park it.
  always_ff @(posedge clk) begin
    if (rdAddrValid) begin
      rdData <= mem[rdAddr];
    end
  end

endmodule : ramFlops

// ==== verilog/fifoCtrl.sv ====
// FIFO controller for a 1R1W flop RAM with a registered pop stage.

`timescale 1ns/1ps

`include "fifoMerge_consts.svh"

module fifoCtrl
  import fifoTypesPkg::*, arbTypesPkg::*;
(
  input  logic     clk,
  input  logic     rst,

  // Push side.
  input  logic     pushValid,
  input  fifoData  pushData,
  output logic     pushReady,

  // Pop side.
  input  logic     popReady,
  output chanBus   pop,

  // Status.
  output fifoCount items,

  // RAM write port.
  output logic     ramWrValid,
  output ramAddr   ramWrAddr,
  output fifoData  ramWrData,

  // RAM read port with data one cycle after the strobe.
  output logic     ramRdAddrValid,
  output ramAddr   ramRdAddr,
  input  fifoData  ramRdData
);

  // The RAM has one entry fewer than the FIFO.
  localparam int RamDepth = `FIFO_DEPTH - 1;

  // ------------------------------
  // State
  // ------------------------------

  // Registered pop stage.
  logic     popValid;
  fifoData  popData;

  // RAM read register holds a word not yet moved to the pop stage.
  logic     rdPending;

  ramAddr   wrPtr;
  ramAddr   rdPtr;

  // Words stored in the RAM, excluding the one in the read register.
  fifoCount ramCount;

  // ------------------------------
  // Handshake and steering
  // ------------------------------

  logic pushFire;
  logic popFire;
  logic stageFree;
  logic ramIdle;
  logic stageLoad;
  logic pushToStage;
  logic pushToRam;
  logic rdIssue;

  // Full exactly when every entry is taken.
  assign pushReady = (items != fifoCount'(`FIFO_DEPTH));
  assign pushFire  = pushValid && pushReady;
  assign popFire   = popValid && popReady;

  // Stage is empty or is emptied this cycle.
  assign stageFree = !popValid || popFire;

  // Nothing older than an incoming push is waiting behind the stage.
  assign ramIdle   = (ramCount == '0) && !rdPending;

  // Returned read data takes the free stage first so order is kept.
  assign stageLoad   = stageFree && rdPending;
  assign pushToStage = pushFire && stageFree && ramIdle;
  assign pushToRam   = pushFire && !pushToStage;

  // Read ahead whenever the read register is free or drains this cycle.
  // Back-to-back reads keep one word per cycle.
  assign rdIssue = (ramCount != '0) && (!rdPending || stageLoad);

  // ------------------------------
  // RAM ports
  // ------------------------------

  assign ramWrValid     = pushToRam;
  assign ramWrAddr      = wrPtr;
  assign ramWrData      = pushData;
  assign ramRdAddrValid = rdIssue;
  assign ramRdAddr      = rdPtr;

  // Pop side straight from the stage registers.
  assign pop.valid = popValid;
  assign pop.data  = popData;

  // ------------------------------
  // Pop stage
  // ------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      popValid <= 1'b0;
    end else if (stageLoad || pushToStage) begin
      popValid <= 1'b1;
    end else if (popFire) begin
      popValid <= 1'b0;
    end
  end

  // Stage payload holds while the pop side stalls.
  always_ff @(posedge clk) begin
    if (stageLoad) begin
      popData <= ramRdData;
    end else if (pushToStage) begin
      popData <= pushData;
    end
  end

  // Read register tracking.
  always_ff @(posedge clk) begin
    if (rst) begin
      rdPending <= 1'b0;
    end else if (rdIssue) begin
      rdPending <= 1'b1;
    end else if (stageLoad) begin
      rdPending <= 1'b0;
    end
  end

  // ------------------------------
  // Pointers and counts
  // ------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      wrPtr <= '0;
      rdPtr <= '0;
    end else begin
      // Pointers wrap at the RAM depth.
      if (pushToRam) begin
        wrPtr <= (wrPtr == ramAddr'(RamDepth - 1)) ? '0 : wrPtr + 1'b1;
      end
      if (rdIssue) begin
        rdPtr <= (rdPtr == ramAddr'(RamDepth - 1)) ? '0 : rdPtr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ramCount <= '0;
    end else begin
      case ({pushToRam, rdIssue})
        2'b10:   ramCount <= ramCount + 1'b1;
        2'b01:   ramCount <= ramCount - 1'b1;
        default: ramCount <= ramCount;
      endcase
    end
  end

  // Total occupancy, unchanged on a push and pop in the same cycle.
  always_ff @(posedge clk) begin
    if (rst) begin
      items <= '0;
    end else begin
      case ({pushFire, popFire})
        2'b10:   items <= items + 1'b1;
        2'b01:   items <= items - 1'b1;
        default: items <= items;
      endcase
    end
  end

endmodule : fifoCtrl

// ==== verilog/fifoFlops.sv ====
// Flop-based FIFO joining the 1R1W controller to a flop RAM.

`timescale 1ns/1ps

`include "fifoMerge_consts.svh"

module fifoFlops
  import fifoTypesPkg::*, arbTypesPkg::*;
#(
  parameter int Depth = `FIFO_DEPTH,
  parameter int Width = `DATA_WIDTH
) (
  input  logic     clk,
  input  logic     rst,

  // Push side.
  input  logic     pushValid,
  input  fifoData  pushData,
  output logic     pushReady,

  // Pop side.
  input  logic     popReady,
  output chanBus   pop,

  // Occupancy.
  output fifoCount items
);

  // The pop stage holds one entry and the RAM holds the rest.
  localparam int RamDepth = Depth - 1;

  // ------------------------------
  // RAM wiring
  // ------------------------------

  logic    ramWrValid;
  ramAddr  ramWrAddr;
  fifoData ramWrData;
  logic    ramRdAddrValid;
  ramAddr  ramRdAddr;
  fifoData ramRdData;

  fifoCtrl fifoCtrl (
    .clk,
    .rst,
    .pushValid,
    .pushData,
    .pushReady,
    .popReady,
    .pop,
    .items,
    .ramWrValid,
    .ramWrAddr,
    .ramWrData,
    .ramRdAddrValid,
    .ramRdAddr,
    .ramRdData
  );

  // Controller never reads and writes one address in the same cycle.
  ramFlops #(
    .Depth(RamDepth),
    .Width(Width)
  ) ramFlops (
    .clk,
    .wrValid(ramWrValid),
    .wrAddr(ramWrAddr),
    .wrData(ramWrData),
    .rdAddrValid(ramRdAddrValid),
    .rdAddr(ramRdAddr),
    .rdData(ramRdData)
  );

endmodule : fifoFlops

// ==== verilog/rrArbiter.sv ====
// Round-robin arbiter merging the channel pop sides onto one tagged output bus.

`timescale 1ns/1ps

`include "fifoMerge_consts.svh"

module rrArbiter
  import arbTypesPkg::*;
(
  input  logic                     clk,
  input  logic                     rst,

  // Pop sides of the channels.
  input  chanBus                   chanIn [`NUM_CHANNELS],
  output logic [`NUM_CHANNELS-1:0] popReady,

  // Shared output.
  output logic                     outValid,
  input  logic                     outReady,
  output outBeat                   out
);

  // ------------------------------
  // Grant
  // ------------------------------

  // Channel with highest priority this cycle.
  chanId prio;

  logic  grantValid;
  chanId grantId;
  chanId candId;

  // First valid channel counting up from the pointer.
  always_comb begin
    grantValid = 1'b0;
    grantId    = prio;
    candId     = prio;
    for (int i = 0; i < `NUM_CHANNELS; i++) begin
      candId = chanId'((int'(prio) + i) % `NUM_CHANNELS);
      if (!grantValid && chanIn[candId].valid) begin
        grantValid = 1'b1;
        grantId    = candId;
      end
    end
  end

  // ------------------------------
  // Output steering
  // ------------------------------

  assign outValid = grantValid;
  assign out.chan = grantId;
  assign out.data = chanIn[grantId].data;

  // Only the granted channel sees the ready.
  always_comb begin
    for (int i = 0; i < `NUM_CHANNELS; i++) begin
      popReady[i] = outReady && grantValid && (grantId == chanId'(i));
    end
  end

  // ------------------------------
  // Priority pointer
  // ------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      prio <= '0;
    end else if (grantValid) begin
      if (outReady) begin
        // Move past the channel just served.
        prio <= chanId'((int'(grantId) + 1) % `NUM_CHANNELS);
      end else begin
        // Park on a stalled grant so the beat holds.
        // A newly valid channel cannot take it over.
        prio <= grantId;
      end
    end
  end

endmodule : rrArbiter

// ==== verilog/fifoMerge.sv ====
// Two-channel merging queue built from per-channel flop FIFOs and a round-robin arbiter.

`timescale 1ns/1ps

`include "fifoMerge_consts.svh"

module fifoMerge
  import fifoTypesPkg::*, arbTypesPkg::*;
(
  input  logic                     clk,
  input  logic                     rst,

  // Push sides, one per channel.
  input  logic [`NUM_CHANNELS-1:0] pushValid,
  input  fifoData                  pushData [`NUM_CHANNELS],
  output logic [`NUM_CHANNELS-1:0] pushReady,

  // Per-channel occupancy.
  output fifoCount                 items [`NUM_CHANNELS],

  // Merged output.
  output logic                     outValid,
  input  logic                     outReady,
  output outBeat                   out
);

  // ------------------------------
  // Channel FIFOs
  // ------------------------------

  chanBus                   chanPop [`NUM_CHANNELS];
  logic [`NUM_CHANNELS-1:0] popReady;

  for (genvar i = 0; i < `NUM_CHANNELS; i++) begin : gChan
    fifoFlops #(
      .Depth(`FIFO_DEPTH),
      .Width(`DATA_WIDTH)
    ) fifoFlops (
      .clk,
      .rst,
      .pushValid(pushValid[i]),
      .pushData(pushData[i]),
      .pushReady(pushReady[i]),
      .popReady(popReady[i]),
      .pop(chanPop[i]),
      .items(items[i])
    );
  end

  // ------------------------------
  // Merge
  // ------------------------------

  rrArbiter rrArbiter (
    .clk,
    .rst,
    .chanIn(chanPop),
    .popReady,
    .outValid,
    .outReady,
    .out
  );

endmodule : fifoMerge

// ==== bench/fifoMergeTb.sv ====
// Testbench for the merging queue that replays a cycle trace against a queue model.

`timescale 1ns/1ps

`include "fifoMerge_consts.svh"

module fifoMergeTb
  import fifoTypesPkg::*, arbTypesPkg::*;
();

  localparam string TracePath = "bench/fifoMerge_trace.txt";
  // Cycles allowed for the final drain.
  localparam int DrainLimit = 64;

  // One trace cycle.
  typedef struct packed {
    logic    pv0;
    fifoData d0;
    logic    pv1;
    fifoData d1;
    logic    ordy;
  } stimLine;

  // ------------------------------
  // DUT and clock
  // ------------------------------

  logic                     clk;
  logic                     rst;
  logic [`NUM_CHANNELS-1:0] pushValid;
  fifoData                  pushData [`NUM_CHANNELS];
  logic [`NUM_CHANNELS-1:0] pushReady;
  fifoCount                 items [`NUM_CHANNELS];
  logic                     outValid;
  logic                     outReady;
  outBeat                   out;

  fifoMerge i_fifoMerge (
    .clk,
    .rst,
    .pushValid,
    .pushData,
    .pushReady,
    .items,
    .outValid,
    .outReady,
    .out
  );

  // 8 ns period.
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // ------------------------------
  // Model state
  // ------------------------------

  stimLine stim [$];
  // Words accepted and not yet popped.
  fifoData modelQ [`NUM_CHANNELS][$];
  // Pop order as listed in the trace.
  fifoData expQ [`NUM_CHANNELS][$];

  // Accepted pushes one and two cycles back.
  logic [`NUM_CHANNELS-1:0] accPrev1;
  logic [`NUM_CHANNELS-1:0] accPrev2;
  logic                     prevFired;
  chanId                    prevChan;
  // Beat seen under a stall that must hold next cycle.
  logic                     holdActive;
  outBeat                   heldBeat;

  // ------------------------------
  // Reporting and compares
  // ------------------------------

  task automatic abortRun(input string msg);
    $display("%s", msg);
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic reportMismatch(input string msg);
    abortRun($sformatf("** Error at %0t ns: %s", $time, msg));
  endtask

  task automatic bitEquals(input logic got, input logic exp, input string what);
    if (got !== exp) reportMismatch($sformatf("%s is %b, expected %b", what, got, exp));
  endtask

  task automatic dataEquals(input fifoData got, input fifoData exp, input string what);
    if (got !== exp) reportMismatch($sformatf("%s is %h, expected %h", what, got, exp));
  endtask

  task automatic chanEquals(input chanId got, input chanId exp, input string what);
    if (got !== exp) reportMismatch($sformatf("%s is %0d, expected %0d", what, got, exp));
  endtask

  task automatic countEquals(input fifoCount got, input fifoCount exp, input string what);
    if (got !== exp) reportMismatch($sformatf("%s is %0d, expected %0d", what, got, exp));
  endtask

  task automatic beatEquals(input outBeat got, input outBeat exp, input string what);
    if (got !== exp) begin
      reportMismatch($sformatf("%s is ch%0d/%h, expected ch%0d/%h",
                               what, got.chan, got.data, exp.chan, exp.data));
    end
  endtask

  // ------------------------------
  // Trace and cycle helpers
  // ------------------------------

  // Reads the cycle lines into stim and the order lines into expQ.
  task automatic loadTrace();
    int      fd;
    int      n;
    int      f [6];
    string   line;
    byte     tag;
    stimLine s;
    fd = $fopen(TracePath, "r");
    if (fd == 0) abortRun({"Could not open the trace file ", TracePath});
    while ($fgets(line, fd) != 0) begin
      tag = line.getc(0);
      if (tag == "C") begin
        n = $sscanf(line, "C %h %h %h %h %h", f[0], f[1], f[2], f[3], f[4]);
        if (n != 5) abortRun({"Malformed cycle line in the trace: ", line});
        s.pv0  = f[0][0];
        s.d0   = fifoData'(f[1]);
        s.pv1  = f[2][0];
        s.d1   = fifoData'(f[3]);
        s.ordy = f[4][0];
        stim.push_back(s);
      end else if (tag == "E") begin
        n = $sscanf(line, "E %h %h %h %h %h %h", f[0], f[1], f[2], f[3], f[4], f[5]);
        if (n != 6 || f[0] >= `NUM_CHANNELS) abortRun({"Malformed order line: ", line});
        for (int k = 1; k < 6; k++) expQ[f[0]].push_back(fifoData'(f[k]));
      end
    end
    $fclose(fd);
    if (stim.size() == 0) abortRun("The trace file holds no cycle lines");
  endtask

  // Checks the settled outputs, drives one cycle and advances the model.
  task automatic runCycle(input stimLine s);
    logic                     seenValid;
    outBeat                   seenBeat;
    logic [`NUM_CHANNELS-1:0] seenReady;
    logic [`NUM_CHANNELS-1:0] accepted;
    logic                     fired;
    chanId                    c;
    chanId                    next;
    seenValid = outValid;
    seenBeat  = out;
    seenReady = pushReady;
    for (int i = 0; i < `NUM_CHANNELS; i++) begin
      countEquals(items[i], fifoCount'(modelQ[i].size()), $sformatf("items of ch%0d", i));
      bitEquals(seenReady[i], modelQ[i].size() != `FIFO_DEPTH,
                $sformatf("pushReady of ch%0d", i));
    end
    // A stalled beat must not change.
    if (holdActive) begin
      bitEquals(seenValid, 1'b1, "outValid under a stall");
      beatEquals(seenBeat, heldBeat, "beat under a stall");
    end
    pushValid   = {s.pv1, s.pv0};
    pushData[0] = s.d0;
    pushData[1] = s.d1;
    outReady    = s.ordy;
    accepted = pushValid & seenReady;
    fired    = seenValid && s.ordy;
    if (fired) begin
      c    = seenBeat.chan;
      next = chanId'((int'(prevChan) + 1) % `NUM_CHANNELS);
      // The next channel is surely pop-valid when it holds words and took no push lately.
      if (prevFired && modelQ[next].size() != 0 && !accPrev1[next] && !accPrev2[next]) begin
        chanEquals(c, next, "channel after a transfer");
      end
      if (modelQ[c].size() == 0) reportMismatch($sformatf("beat from empty ch%0d", c));
      if (expQ[c].size() == 0) reportMismatch($sformatf("ch%0d beat beyond trace order", c));
      dataEquals(seenBeat.data, modelQ[c][0], "beat data against push order");
      dataEquals(seenBeat.data, expQ[c][0], "beat data against trace order");
      modelQ[c].delete(0);
      expQ[c].delete(0);
      prevChan = c;
    end
    for (int i = 0; i < `NUM_CHANNELS; i++) begin
      if (accepted[i]) modelQ[i].push_back(pushData[i]);
    end
    holdActive = seenValid && !s.ordy;
    heldBeat   = seenBeat;
    prevFired  = fired;
    accPrev2   = accPrev1;
    accPrev1   = accepted;
    @(negedge clk);
  endtask

  function automatic int wordsLeft();
    int total;
    total = 0;
    for (int i = 0; i < `NUM_CHANNELS; i++) total += modelQ[i].size();
    return total;
  endfunction

  // Idle pushes with the output open until the model holds no words.
  task automatic drainQueues();
    stimLine idle;
    int      waited;
    idle      = '0;
    idle.ordy = 1'b1;
    waited    = 0;
    while (wordsLeft() != 0) begin
      if (waited == DrainLimit) begin
        abortRun($sformatf("Timeout: the queues did not drain within %0d cycles", DrainLimit));
      end
      runCycle(idle);
      waited++;
    end
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------

  initial begin
    rst      = 1'b1;
    pushValid = '0;
    for (int i = 0; i < `NUM_CHANNELS; i++) pushData[i] = '0;
    outReady   = 1'b0;
    accPrev1   = '0;
    accPrev2   = '0;
    prevFired  = 1'b0;
    prevChan   = '1;
    holdActive = 1'b0;
    heldBeat   = '0;
    loadTrace();
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    // State right after reset.
    bitEquals(outValid, 1'b0, "outValid after reset");
    for (int i = 0; i < `NUM_CHANNELS; i++) begin
      bitEquals(pushReady[i], 1'b1, $sformatf("pushReady of ch%0d after reset", i));
      countEquals(items[i], '0, $sformatf("items of ch%0d after reset", i));
    end
    foreach (stim[k]) runCycle(stim[k]);
    drainQueues();
    bitEquals(outValid, 1'b0, "outValid after drain");
    for (int i = 0; i < `NUM_CHANNELS; i++) begin
      countEquals(items[i], '0, $sformatf("items of ch%0d after drain", i));
      if (expQ[i].size() != 0) begin
        abortRun($sformatf("Channel %0d never delivered %0d words of the trace order",
                           i, expQ[i].size()));
      end
    end
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule : fifoMergeTb

// ==== fifoMerge.f ====
+incdir+verilog
verilog/fifoTypesPkg.sv
verilog/arbTypesPkg.sv
verilog/ramFlops.sv
verilog/fifoCtrl.sv
verilog/fifoFlops.sv
verilog/rrArbiter.sv
verilog/fifoMerge.sv
bench/fifoMergeTb.sv

// ==== Makefile ====
# Verilator build for the merging queue testbench.

VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/1ps
TOP       = fifoMergeTb
FILELIST  = fifoMerge.f
OBJDIR    = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# The simulator exits with a failing status when the testbench stops on an error.
run: compile
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)

// ==== bench/fifoMerge_trace.txt ====
# C pushValid0 pushData0 pushValid1 pushData1 outReady : one line per clock cycle, hex
# E chan word word word word word : expected pop order of that channel, hex
# Fill both channels while the output is stalled.
C 1 1001 1 2001 0
C 1 1002 1 2002 0
C 1 1003 1 2003 0
C 1 1004 1 2004 0
C 1 1005 1 2005 0
C 1 1006 1 2006 0
C 1 1007 1 2007 0
C 1 1008 1 2008 0
# Both channels are full, these words are refused.
C 1 1009 1 2009 0
# Short transfers mixed with stalls and pushes near the full mark.
C 0 0000 0 0000 1
C 1 100a 0 0000 1
C 0 0000 1 200a 0
C 0 0000 0 0000 0
C 1 100b 1 200b 1
C 1 100b 0 0000 1
C 0 0000 1 200b 1
# Expected order per channel, the refused words are absent.
E 0 1001 1002 1003 1004 1005
E 0 1006 1007 1008 100a 100b
E 1 2001 2002 2003 2004 2005
E 1 2006 2007 2008 200a 200b
